//--- src/mips_pkg.sv
package mips_pkg;

	localparam int WORD_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int MEM_DEPTH  = 1024;
	localparam int MEM_ADDR_W = 10;
	localparam logic [WORD_W-1:0] START_ADDR = 32'h8002_0000;

	// Primary opcodes
	localparam logic [5:0] OP_RTYPE = 6'b000000;
	localparam logic [5:0] OP_MUL   = 6'b011100; // SPECIAL2
	localparam logic [5:0] OP_ADDI  = 6'b001000;
	localparam logic [5:0] OP_ADDIU = 6'b001001;
	localparam logic [5:0] OP_SLTI  = 6'b001010;
	localparam logic [5:0] OP_SLTIU = 6'b001011;
	localparam logic [5:0] OP_ORI   = 6'b001101;
	localparam logic [5:0] OP_XORI  = 6'b001110;
	localparam logic [5:0] OP_LUI   = 6'b001111;

	// Function codes
	localparam logic [5:0] FN_ADD  = 6'b100000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUB  = 6'b100010;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_SRA  = 6'b000011;
	localparam logic [5:0] FN_SLLV = 6'b000100;
	localparam logic [5:0] FN_SRLV = 6'b000110;
	localparam logic [5:0] FN_SRAV = 6'b000111;
	localparam logic [5:0] FN_MUL  = 6'b000010; // Only under OP_MUL

	typedef enum logic [WORD_W-1:0] {
		ALU_ADD, ALU_SUB, ALU_MUL, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} alu_op_e;

	// Immediate is {rd, sa, func}
	typedef struct packed {
		logic [5:0]            opcode;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [REG_ADDR_W-1:0] rd;
		logic [4:0]            sa;
		logic [5:0]            func;
	} insn_fields_t;

	typedef struct packed {
		logic              valid;
		logic [WORD_W-1:0] pc;
		logic [WORD_W-1:0] insn;
	} fetch_t;

	typedef struct packed {
		logic                  valid;
		logic                  writes;
		logic [WORD_W-1:0]     pc;
		alu_op_e               alu_op;
		logic [WORD_W-1:0]     operand_a;
		logic [WORD_W-1:0]     operand_b;
		logic [4:0]            shamt;
		logic [REG_ADDR_W-1:0] dest;
	} exec_t;

	typedef struct packed {
		logic                  valid;
		logic [WORD_W-1:0]     pc;
		logic [REG_ADDR_W-1:0] dest;
		logic [WORD_W-1:0]     data;
	} wb_t;

endpackage

//--- src/insn_memory.sv
`timescale 1ns/1ps

module insn_memory (
	input  logic                            clock,
	input  logic                            load_en,
	input  logic [mips_pkg::MEM_ADDR_W-1:0] load_addr,
	input  logic [mips_pkg::WORD_W-1:0]     load_data,
	input  logic [mips_pkg::MEM_ADDR_W-1:0] rd_addr,
	output logic [mips_pkg::WORD_W-1:0]     rd_data
);
	import mips_pkg::*;

	logic [WORD_W-1:0] mem [MEM_DEPTH];

	// Program load, one word per strobe
	always_ff @(posedge clock) begin
		if (load_en) begin
			mem[load_addr] <= load_data;
		end
	end

	always_ff @(posedge clock) begin
		rd_data <= mem[rd_addr]; // Registered read
	end

endmodule

//--- src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
	input  logic                            clock,
	input  logic                            rst_n,
	input  logic                            run,
	output logic [mips_pkg::MEM_ADDR_W-1:0] mem_addr,
	input  logic [mips_pkg::WORD_W-1:0]     mem_data,
	output mips_pkg::fetch_t                fetch
);
	import mips_pkg::*;

	logic [WORD_W-1:0] pc;
	logic [WORD_W-1:0] pc_q;
	logic [WORD_W-1:0] offset;
	logic              valid_q;

	assign offset   = pc - START_ADDR;
	assign mem_addr = offset[MEM_ADDR_W+1:2]; // Byte offset to word index

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pc      <= START_ADDR;
			pc_q    <= START_ADDR;
			valid_q <= 1'b0;
		end else begin
			pc_q    <= pc; // Lines up with the memory data
			valid_q <= run;
			if (run) begin
				pc <= pc + 32'd4;
			end
		end
	end

	assign fetch = '{valid: valid_q, pc: pc_q, insn: mem_data};

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                            clock,
	input  logic                            rst_n,
	input  logic [mips_pkg::REG_ADDR_W-1:0] rs_addr,
	input  logic [mips_pkg::REG_ADDR_W-1:0] rt_addr,
	output logic [mips_pkg::WORD_W-1:0]     rs_data,
	output logic [mips_pkg::WORD_W-1:0]     rt_data,
	input  logic                            we,
	input  logic [mips_pkg::REG_ADDR_W-1:0] wr_addr,
	input  logic [mips_pkg::WORD_W-1:0]     wr_data
);
	import mips_pkg::*;

	logic [WORD_W-1:0] regs [2**REG_ADDR_W];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**REG_ADDR_W; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// r0 reads zero, same-cycle write goes straight through
	assign rs_data = (rs_addr == '0) ? '0 :
		(we && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? '0 :
		(we && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

endmodule

//--- src/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
	input  logic                            clock,
	input  logic                            rst_n,
	input  mips_pkg::fetch_t                fetch,
	input  logic                            we,
	input  logic [mips_pkg::REG_ADDR_W-1:0] wr_addr,
	input  logic [mips_pkg::WORD_W-1:0]     wr_data,
	output mips_pkg::exec_t                 exec
);
	import mips_pkg::*;

	insn_fields_t          f;
	logic [15:0]           imm;
	logic [WORD_W-1:0]     rs_data;
	logic [WORD_W-1:0]     rt_data;
	logic [WORD_W-1:0]     imm_sext;
	logic [WORD_W-1:0]     imm_zext;
	alu_op_e               alu_op;
	logic [WORD_W-1:0]     operand_b;
	logic [4:0]            shamt;
	logic [REG_ADDR_W-1:0] dest;
	logic                  supported;

	assign f        = insn_fields_t'(fetch.insn);
	assign imm      = {f.rd, f.sa, f.func};
	assign imm_sext = {{16{imm[15]}}, imm};
	assign imm_zext = {16'b0, imm};

	reg_file u_reg_file (
		.clock   (clock),
		.rst_n   (rst_n),
		.rs_addr (f.rs),
		.rt_addr (f.rt),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.we      (we),
		.wr_addr (wr_addr),
		.wr_data (wr_data)
	);

	always_comb begin
		alu_op    = ALU_ADD;
		operand_b = rt_data;
		shamt     = f.sa;
		dest      = f.rt; // I-type default
		supported = 1'b1;
		case (f.opcode)
			OP_RTYPE: begin
				dest = f.rd;
				case (f.func)
					FN_ADD, FN_ADDU: alu_op = ALU_ADD; // No overflow trap
					FN_SUB, FN_SUBU: alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_XOR:  alu_op = ALU_XOR;
					FN_NOR:  alu_op = ALU_NOR;
					FN_SLT:  alu_op = ALU_SLT;
					FN_SLTU: alu_op = ALU_SLTU;
					FN_SLL:  alu_op = ALU_SLL;
					FN_SRL:  alu_op = ALU_SRL;
					FN_SRA:  alu_op = ALU_SRA;
					FN_SLLV: begin
						alu_op = ALU_SLL;
						shamt  = rs_data[4:0];
					end
					FN_SRLV: begin
						alu_op = ALU_SRL;
						shamt  = rs_data[4:0];
					end
					FN_SRAV: begin
						alu_op = ALU_SRA;
						shamt  = rs_data[4:0];
					end
					default: supported = 1'b0;
				endcase
			end
			OP_MUL: begin
				dest      = f.rd;
				alu_op    = ALU_MUL;
				supported = (f.func == FN_MUL);
			end
			OP_ADDI, OP_ADDIU: operand_b = imm_sext;
			OP_SLTI: begin
				alu_op    = ALU_SLT;
				operand_b = imm_sext;
			end
			OP_SLTIU: begin
				alu_op    = ALU_SLTU;
				operand_b = imm_sext; // Sign-extended, then compared unsigned
			end
			OP_ORI: begin
				alu_op    = ALU_OR;
				operand_b = imm_zext;
			end
			OP_XORI: begin
				alu_op    = ALU_XOR;
				operand_b = imm_zext;
			end
			OP_LUI: begin
				alu_op    = ALU_LUI;
				operand_b = imm_zext;
			end
			default: supported = 1'b0;
		endcase
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			exec <= '0;
		end else begin
			exec.valid     <= fetch.valid;
			exec.writes    <= supported && dest != '0;
			exec.pc        <= fetch.pc;
			exec.alu_op    <= alu_op;
			exec.operand_a <= rs_data;
			exec.operand_b <= operand_b;
			exec.shamt     <= shamt;
			exec.dest      <= dest;
		end
	end

endmodule

//--- src/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
	input  logic                            clock,
	input  logic                            rst_n,
	input  mips_pkg::exec_t                 exec,
	output logic                            we,
	output logic [mips_pkg::REG_ADDR_W-1:0] wr_addr,
	output logic [mips_pkg::WORD_W-1:0]     wr_data,
	output mips_pkg::wb_t                   wb
);
	import mips_pkg::*;

	logic [WORD_W-1:0] a;
	logic [WORD_W-1:0] b;
	logic [WORD_W-1:0] result;

	assign a = exec.operand_a;
	assign b = exec.operand_b;

	always_comb begin
		case (exec.alu_op)
			ALU_ADD:  result = a + b;
			ALU_SUB:  result = a - b;
			ALU_MUL:  result = a * b; // Low word of the product
			ALU_AND:  result = a & b;
			ALU_OR:   result = a | b;
			ALU_XOR:  result = a ^ b;
			ALU_NOR:  result = ~(a | b);
			ALU_SLT:  result = {{(WORD_W-1){1'b0}}, $signed(a) < $signed(b)};
			ALU_SLTU: result = {{(WORD_W-1){1'b0}}, a < b};
			ALU_SLL:  result = b << exec.shamt;
			ALU_SRL:  result = b >> exec.shamt;
			ALU_SRA:  result = $signed(b) >>> exec.shamt;
			ALU_LUI:  result = b << 16;
			default:  result = '0;
		endcase
	end

	// Register write lands on the same edge as wb
	assign we      = exec.valid && exec.writes; // Bubbles write nothing
	assign wr_addr = exec.dest;
	assign wr_data = result;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wb <= '0;
		end else begin
			wb <= '{valid: we, pc: exec.pc, dest: exec.dest, data: result};
		end
	end

endmodule

//--- src/cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
	input  logic                            clock,
	input  logic                            rst_n,
	input  logic                            run,
	input  logic                            load_en,
	input  logic [mips_pkg::MEM_ADDR_W-1:0] load_addr,
	input  logic [mips_pkg::WORD_W-1:0]     load_data,
	output mips_pkg::wb_t                   wb
);
	import mips_pkg::*;

	logic [MEM_ADDR_W-1:0] mem_addr;
	logic [WORD_W-1:0]     mem_data;
	fetch_t                fetch;
	exec_t                 exec;
	logic                  we;
	logic [REG_ADDR_W-1:0] wr_addr;
	logic [WORD_W-1:0]     wr_data;

	insn_memory u_insn_memory (
		.clock     (clock),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.rd_addr   (mem_addr),
		.rd_data   (mem_data)
	);

	fetch_unit u_fetch_unit (
		.clock    (clock),
		.rst_n    (rst_n),
		.run      (run),
		.mem_addr (mem_addr),
		.mem_data (mem_data),
		.fetch    (fetch)
	);

	// Register writes come back from execute
	decode_unit u_decode_unit (
		.clock   (clock),
		.rst_n   (rst_n),
		.fetch   (fetch),
		.we      (we),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.exec    (exec)
	);

	execute_unit u_execute_unit (
		.clock   (clock),
		.rst_n   (rst_n),
		.exec    (exec),
		.we      (we),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.wb      (wb)
	);

endmodule

//--- testbench/cpu_core_tests.svh
task automatic alu_arith_test();
	prog.delete();
	prog.push_back(itype_word(OP_ADDI, 5'd1, 5'd0, 16'hfffb)); // r1 = -5
	prog.push_back(itype_word(OP_ADDI, 5'd2, 5'd0, 16'd1234));
	prog.push_back(itype_word(OP_ADDIU, 5'd3, 5'd2, 16'h7fff));
	prog.push_back(rtype_word(FN_ADD, 5'd4, 5'd1, 5'd2, 5'd0));
	prog.push_back(rtype_word(FN_ADDU, 5'd5, 5'd3, 5'd1, 5'd0));
	prog.push_back(rtype_word(FN_SUB, 5'd6, 5'd1, 5'd2, 5'd0));
	prog.push_back(rtype_word(FN_SUBU, 5'd7, 5'd2, 5'd3, 5'd0));
	prog.push_back(mul_word(5'd8, 5'd1, 5'd3));
	prog.push_back(rtype_word(FN_AND, 5'd9, 5'd1, 5'd3, 5'd0));
	prog.push_back(rtype_word(FN_OR, 5'd10, 5'd1, 5'd2, 5'd0));
	prog.push_back(rtype_word(FN_XOR, 5'd11, 5'd1, 5'd3, 5'd0));
	prog.push_back(rtype_word(FN_NOR, 5'd12, 5'd2, 5'd3, 5'd0));
	run_program(0, 0);
endtask

task automatic shift_compare_test();
	prog.delete();
	prog.push_back(itype_word(OP_ADDI, 5'd1, 5'd0, 16'h8000)); // Most negative imm
	prog.push_back(itype_word(OP_ADDI, 5'd2, 5'd0, 16'd100));
	prog.push_back(rtype_word(FN_SLL, 5'd3, 5'd0, 5'd1, 5'd4));
	prog.push_back(rtype_word(FN_SRL, 5'd4, 5'd0, 5'd1, 5'd4));
	prog.push_back(rtype_word(FN_SRA, 5'd5, 5'd0, 5'd1, 5'd4));
	prog.push_back(itype_word(OP_ADDI, 5'd6, 5'd0, 16'd35)); // Only low 5 bits shift
	prog.push_back(rtype_word(FN_SLLV, 5'd7, 5'd6, 5'd1, 5'd0));
	prog.push_back(rtype_word(FN_SRLV, 5'd8, 5'd6, 5'd1, 5'd0));
	prog.push_back(rtype_word(FN_SRAV, 5'd9, 5'd6, 5'd1, 5'd0));
	prog.push_back(rtype_word(FN_SLT, 5'd10, 5'd1, 5'd2, 5'd0));
	prog.push_back(rtype_word(FN_SLTU, 5'd11, 5'd1, 5'd2, 5'd0));
	prog.push_back(itype_word(OP_SLTI, 5'd12, 5'd2, 16'hffff)); // 100 < -1 is false
	prog.push_back(itype_word(OP_SLTIU, 5'd13, 5'd2, 16'hffff));
	prog.push_back(itype_word(OP_ORI, 5'd14, 5'd2, 16'h8001));
	prog.push_back(itype_word(OP_XORI, 5'd15, 5'd1, 16'hffff));
	prog.push_back(itype_word(OP_LUI, 5'd16, 5'd0, 16'h8765));
	run_program(0, 0);
endtask

// Each instruction reads the one right before it
task automatic bypass_chain_test();
	prog.delete();
	prog.push_back(itype_word(OP_ADDI, 5'd1, 5'd0, 16'd3));
	prog.push_back(rtype_word(FN_ADDU, 5'd2, 5'd1, 5'd1, 5'd0));
	prog.push_back(mul_word(5'd3, 5'd2, 5'd1));
	prog.push_back(rtype_word(FN_SLLV, 5'd4, 5'd1, 5'd3, 5'd0));
	prog.push_back(rtype_word(FN_SUBU, 5'd5, 5'd4, 5'd3, 5'd0));
	prog.push_back(rtype_word(FN_XOR, 5'd1, 5'd5, 5'd1, 5'd0));
	prog.push_back(rtype_word(FN_SRA, 5'd6, 5'd0, 5'd1, 5'd1));
	prog.push_back(rtype_word(FN_SLT, 5'd7, 5'd6, 5'd5, 5'd0));
	run_program(0, 0);
endtask

task automatic no_writeback_test();
	prog.delete();
	prog.push_back(itype_word(OP_ADDI, 5'd1, 5'd0, 16'd7));
	prog.push_back(32'h0000_0000); // NOP
	prog.push_back(itype_word(6'b100011, 5'd4, 5'd1, 16'd8)); // LW, not supported
	prog.push_back(rtype_word(6'b011000, 5'd6, 5'd1, 5'd1, 5'd0)); // MULT
	prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd1, 16'd5));
	prog.push_back(rtype_word(FN_ADD, 5'd2, 5'd0, 5'd1, 5'd0));
	prog.push_back(rtype_word(FN_OR, 5'd3, 5'd4, 5'd6, 5'd0));
	prog.push_back(rtype_word(FN_SUB, 5'd5, 5'd1, 5'd0, 5'd0));
	run_program(0, 0);
endtask

task automatic run_pause_test();
	prog.delete();
	for (int k = 0; k < 10; k++) begin
		prog.push_back(itype_word(OP_ADDIU, 5'(k + 1), 5'(k), 16'(3 * k + 1)));
	end
	run_program(4, 5); // Five idle cycles after the fourth fetch
endtask

task automatic random_program_test();
	logic [5:0]  rfuncs [12];
	logic [5:0]  iops [7];
	int          kind;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  rd;
	logic [4:0]  sa;
	logic [15:0] imm;
	rfuncs = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
		FN_SLT, FN_SLTU, FN_SLL, FN_SRAV};
	iops   = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ORI, OP_XORI, OP_LUI};
	prog.delete();
	for (int n = 0; n < 40; n++) begin
		kind = rand_below(20);
		rs   = 5'(rand_below(32));
		rt   = 5'(rand_below(32));
		rd   = 5'(rand_below(32));
		sa   = 5'(rand_below(32));
		imm  = 16'(rand_below(65536));
		if (kind < 12) begin
			prog.push_back(rtype_word(rfuncs[kind], rd, rs, rt, sa));
		end else if (kind == 12) begin
			prog.push_back(mul_word(rd, rs, rt));
		end else begin
			prog.push_back(itype_word(iops[kind - 13], rt, rs, imm));
		end
	end
	run_program(0, 0);
endtask

//--- testbench/cpu_core_tb.sv
`timescale 1ns/1ps

module cpu_core_tb;
	import mips_pkg::*;

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 8;
	localparam int PIPE_DEPTH   = 3; // Fetch to wb latency in edges
	localparam int DRAIN_LIMIT  = 8;
	localparam int NUM_TESTS    = 6;
	localparam int TOTAL_INSNS  = 94;

	logic                  clock;
	logic                  rst_n;
	logic                  run;
	logic                  load_en;
	logic [MEM_ADDR_W-1:0] load_addr;
	logic [WORD_W-1:0]     load_data;
	wb_t                   wb;

	logic [WORD_W-1:0] prog [$];
	wb_t               got [$];
	wb_t               exp_q [$];
	logic [WORD_W-1:0] model_regs [32];
	integer            seed;

	cpu_core dut (
		.clock     (clock),
		.rst_n     (rst_n),
		.run       (run),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.wb        (wb)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	always @(posedge clock) begin
		if (rst_n && wb.valid) begin
			got.push_back(wb);
		end
	end

	function automatic logic [WORD_W-1:0] rtype_word(input logic [5:0] func,
			input logic [4:0] rd, rs, rt, sa);
		return {OP_RTYPE, rs, rt, rd, sa, func};
	endfunction

	function automatic logic [WORD_W-1:0] itype_word(input logic [5:0] op,
			input logic [4:0] rt, rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [WORD_W-1:0] mul_word(input logic [4:0] rd, rs, rt);
		return {OP_MUL, rs, rt, rd, 5'd0, FN_MUL};
	endfunction

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	task automatic check_wb(input wb_t got_wb, input wb_t exp_wb);
		if (got_wb !== exp_wb) begin
			$display("Mismatch at %0t: got pc %h dest %0d data %h valid %b", $time,
				got_wb.pc, got_wb.dest, got_wb.data, got_wb.valid);
			$display("    expected pc %h dest %0d data %h", exp_wb.pc, exp_wb.dest, exp_wb.data);
			$display("test failed");
			$fatal(1, "writeback compare error");
		end
	endtask

	task automatic check_count(input int got_n, input int exp_n);
		if (got_n != exp_n) begin
			$display("Wrong number of writebacks at %0t: saw %0d, expected %0d", $time,
				got_n, exp_n);
			$display("test failed");
			$fatal(1, "writeback count error");
		end
	endtask

	// Reference model of one instruction
	task automatic model_execute(input logic [WORD_W-1:0] insn, input logic [WORD_W-1:0] pc);
		logic [5:0]        op;
		logic [5:0]        func;
		logic [4:0]        sa;
		logic [4:0]        dst;
		logic [WORD_W-1:0] a;
		logic [WORD_W-1:0] b;
		logic [WORD_W-1:0] simm;
		logic [WORD_W-1:0] zimm;
		logic [WORD_W-1:0] res;
		logic              ok;
		wb_t               e;
		op   = insn[31:26];
		func = insn[5:0];
		sa   = insn[10:6];
		a    = model_regs[insn[25:21]];
		b    = model_regs[insn[20:16]];
		simm = {{16{insn[15]}}, insn[15:0]};
		zimm = {16'h0, insn[15:0]};
		dst  = insn[20:16];
		ok   = 1'b1;
		res  = '0;
		case (op)
			OP_RTYPE: begin
				dst = insn[15:11];
				case (func)
					FN_ADD, FN_ADDU: res = a + b;
					FN_SUB, FN_SUBU: res = a - b;
					FN_AND:  res = a & b;
					FN_OR:   res = a | b;
					FN_XOR:  res = a ^ b;
					FN_NOR:  res = ~(a | b);
					FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
					FN_SLL:  res = b << sa;
					FN_SRL:  res = b >> sa;
					FN_SRA:  res = $signed(b) >>> sa;
					FN_SLLV: res = b << a[4:0];
					FN_SRLV: res = b >> a[4:0];
					FN_SRAV: res = $signed(b) >>> a[4:0];
					default: ok = 1'b0;
				endcase
			end
			OP_MUL: begin
				dst = insn[15:11];
				ok  = (func == FN_MUL);
				res = a * b;
			end
			OP_ADDI, OP_ADDIU: res = a + simm;
			OP_SLTI:  res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
			OP_SLTIU: res = (a < simm) ? 32'd1 : 32'd0;
			OP_ORI:   res = a | zimm;
			OP_XORI:  res = a ^ zimm;
			OP_LUI:   res = {insn[15:0], 16'h0};
			default:  ok = 1'b0;
		endcase
		if (ok && dst != 5'd0) begin
			model_regs[dst] = res;
			e.valid = 1'b1;
			e.pc    = pc;
			e.dest  = dst;
			e.data  = res;
			exp_q.push_back(e);
		end
	endtask

	task automatic reset_core();
		@(posedge clock);
		rst_n   <= 1'b0;
		run     <= 1'b0;
		load_en <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		rst_n <= 1'b1;
		got.delete();
	endtask

	task automatic load_program();
		for (int i = 0; i < prog.size(); i++) begin
			@(posedge clock);
			load_en   <= 1'b1;
			load_addr <= MEM_ADDR_W'(i);
			load_data <= prog[i];
		end
		@(posedge clock);
		load_en <= 1'b0;
	endtask

	// Fresh core, load, run with an optional gap in run, then compare
	task automatic run_program(input int pause_at, input int pause_len);
		int cycles;
		reset_core();
		load_program();
		exp_q.delete();
		for (int r = 0; r < 32; r++) begin
			model_regs[r] = '0;
		end
		for (int i = 0; i < prog.size(); i++) begin
			model_execute(prog[i], START_ADDR + 32'(4 * i));
		end
		@(posedge clock);
		run <= 1'b1;
		for (int i = 0; i < prog.size(); i++) begin
			@(posedge clock);
			if (i + 1 == pause_at) begin
				run <= 1'b0;
				repeat (pause_len) @(posedge clock);
				run <= 1'b1;
			end
		end
		run <= 1'b0;
		cycles = 0;
		while (got.size() < exp_q.size() && cycles < DRAIN_LIMIT) begin
			@(posedge clock);
			cycles++;
		end
		repeat (PIPE_DEPTH) @(posedge clock); // Catch any extra writeback
		check_count(got.size(), exp_q.size());
		foreach (exp_q[i]) begin
			check_wb(got[i], exp_q[i]);
		end
	endtask

	`include "cpu_core_tests.svh"

	initial begin
		#((2 * TOTAL_INSNS + 40 * NUM_TESTS) * CLK_PERIOD);
		$display("Timeout: the tests did not finish in time");
		$display("test failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		seed      = 88369;
		clock     = 1'b0;
		rst_n     = 1'b0;
		run       = 1'b0;
		load_en   = 1'b0;
		load_addr = '0;
		load_data = '0;
		alu_arith_test();
		shift_compare_test();
		bypass_chain_test();
		no_writeback_test();
		run_pause_test();
		random_program_test();
		$display("test passed");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+testbench
src/mips_pkg.sv
src/insn_memory.sv
src/fetch_unit.sv
src/reg_file.sv
src/decode_unit.sv
src/execute_unit.sv
src/cpu_core.sv
testbench/cpu_core_tb.sv
